/* src/led_matrix_macros.svh */
// panel geometry, serial and scan timing, command opcodes
`ifndef LED_MATRIX_MACROS_SVH
`define LED_MATRIX_MACROS_SVH

`define LM_COLS          16     // panel width
`define LM_COL_BITS      4
`define LM_SCAN_ROWS     8      // row pairs, top and bottom half
`define LM_ROW_BITS      3
`define LM_PLANES        4      // binary-coded brightness bits per colour

`define LM_TICKS_PER_BIT 8      // clk_root cycles per uart bit
`define LM_SLOT_CYCLES   4      // clk_root cycles per shifted column
`define LM_OE_UNIT       8      // display cycles of plane 0

`define LM_OP_PIXEL      8'h50
`define LM_OP_ENABLE     8'h45
`define LM_OP_PLANES     8'h54

`endif

/* src/led_matrix_pkg.sv */
// shared packed types of the led matrix driver
// pixel, frame write, display masks and hub75 panel bundle
`include "led_matrix_macros.svh"

package led_matrix_pkg;

    typedef logic [`LM_COL_BITS-1:0]        col_t;
    typedef logic [`LM_ROW_BITS-1:0]        row_t;
    typedef logic [$clog2(`LM_PLANES)-1:0]  plane_t;

    // panel row in the upper nibble, bit 7 selects the bottom half
    typedef logic [`LM_ROW_BITS+`LM_COL_BITS:0] fb_addr_t;

    typedef struct packed {
        logic [`LM_PLANES-1:0] red;
        logic [`LM_PLANES-1:0] green;
        logic [`LM_PLANES-1:0] blue;
    } pixel_t;

    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_t;

    typedef struct packed {
        logic [2:0]            rgb_enable;    // bit 0 red, 1 green, 2 blue
        logic [`LM_PLANES-1:0] plane_enable;
    } display_ctrl_t;

    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    typedef struct packed {
        logic [2:0] rgb_top;
        logic [2:0] rgb_bottom;
        row_t       row_addr;
        logic       clk_pixel;
        logic       row_latch;
        logic       oe_n;
    } hub75_t;

endpackage

/* src/uart_byte_rx.sv */
// 8N1 uart receiver, one byte per stop bit with a single-cycle valid
`timescale 1ns/1ns
`include "led_matrix_macros.svh"

module uart_byte_rx (
    input  logic       clk_root,
    input  logic       arst_n,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int TW = $clog2(`LM_TICKS_PER_BIT);
    localparam logic [TW-1:0] TICK_LAST = TW'(`LM_TICKS_PER_BIT - 1);
    localparam logic [TW-1:0] TICK_HALF = TW'(`LM_TICKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_DATA, ST_STOP} rx_state_t;

    rx_state_t   state;
    logic [1:0]  rxd_sync;   // two-flop synchroniser, idles high
    logic        rxd_s;
    logic [TW-1:0] tick;
    logic [2:0]  bit_idx;
    logic [7:0]  shift_q;

    assign rxd_s   = rxd_sync[1];
    assign rx_byte = shift_q;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rxd_sync <= 2'b11;
            state    <= ST_IDLE;
            tick     <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    tick <= '0;
                    if (!rxd_s) state <= ST_START;   // falling edge of start bit
                end
                ST_START: begin
                    tick <= tick + 1'b1;
                    if (tick == TICK_HALF) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? ST_IDLE : ST_DATA;  // glitch, not a start
                    end
                end
                ST_DATA: begin
                    tick <= tick + 1'b1;
                    if (tick == TICK_LAST) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= ST_STOP;
                    end
                end
                ST_STOP: begin
                    tick <= tick + 1'b1;
                    if (tick == TICK_LAST) begin
                        rx_valid <= rxd_s;   // framing error drops the byte
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // lsb first, sampled mid-bit
    always_ff @(posedge clk_root) begin
        if (state == ST_DATA && tick == TICK_LAST) shift_q <= {rxd_s, shift_q[7:1]};
    end

    a_valid_single: assert property (@(posedge clk_root) disable iff (!arst_n)
        rx_valid |=> !rx_valid);

endmodule

/* src/command_decoder.sv */
// serial command parser
// pixel writes into the frame memory, colour and plane enable masks
`timescale 1ns/1ns
`include "led_matrix_macros.svh"

module command_decoder (
    input  logic                          clk_root,
    input  logic                          arst_n,
    input  logic [7:0]                    rx_byte,
    input  logic                          rx_valid,
    output led_matrix_pkg::fb_write_t     fb_write,
    output led_matrix_pkg::display_ctrl_t display_ctrl
);

    logic [7:0] op_q;
    logic [2:0] idx_q;     // byte position within the command
    logic [3:0] row_q;
    logic [3:0] col_q;
    logic [7:0] rg_q;      // red high nibble, green low nibble

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            op_q                      <= '0;
            idx_q                     <= '0;
            fb_write                  <= '0;
            display_ctrl.rgb_enable   <= '1;
            display_ctrl.plane_enable <= '1;
        end else begin
            fb_write.en <= 1'b0;
            if (rx_valid) begin
                if (idx_q == 3'd0) begin
                    op_q <= rx_byte;
                    case (rx_byte)
                        `LM_OP_PIXEL, `LM_OP_ENABLE, `LM_OP_PLANES: idx_q <= 3'd1;
                        default: idx_q <= 3'd0;   // unknown opcode dropped
                    endcase
                end else begin
                    idx_q <= idx_q + 1'b1;
                    case (op_q)
                        `LM_OP_PIXEL: begin
                            if (idx_q == 3'd4) begin
                                fb_write.en         <= 1'b1;
                                fb_write.addr       <= {row_q, col_q};
                                fb_write.data.red   <= rg_q[7:4];
                                fb_write.data.green <= rg_q[3:0];
                                fb_write.data.blue  <= rx_byte[`LM_PLANES-1:0];
                                idx_q               <= 3'd0;
                            end
                        end
                        `LM_OP_ENABLE: begin
                            display_ctrl.rgb_enable <= rx_byte[2:0];
                            idx_q                   <= 3'd0;
                        end
                        `LM_OP_PLANES: begin
                            display_ctrl.plane_enable <= rx_byte[`LM_PLANES-1:0];
                            idx_q                     <= 3'd0;
                        end
                        default: idx_q <= 3'd0;
                    endcase
                end
            end
        end
    end

    // pixel arguments
    always_ff @(posedge clk_root) begin
        if (rx_valid && op_q == `LM_OP_PIXEL) begin
            case (idx_q)
                3'd1: row_q <= rx_byte[3:0];
                3'd2: col_q <= rx_byte[3:0];
                3'd3: rg_q  <= rx_byte;
                default: ;
            endcase
        end
    end

    // bytes arrive at least a uart frame apart
    a_write_single: assert property (@(posedge clk_root) disable iff (!arst_n)
        fb_write.en |=> !fb_write.en);

endmodule

/* src/frame_memory.sv */
// frame memory, one pixel per word
// write port from the decoder, registered read port for the fetch
`timescale 1ns/1ns

module frame_memory (
    input  logic                       clk_root,
    input  led_matrix_pkg::fb_write_t  fb_write,
    input  led_matrix_pkg::fb_addr_t   rd_addr,
    output led_matrix_pkg::pixel_t     rd_data
);

    localparam int DEPTH = 1 << $bits(led_matrix_pkg::fb_addr_t);

    led_matrix_pkg::pixel_t mem [DEPTH];

    // panel starts dark
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_root) begin
        if (fb_write.en) begin
            mem[fb_write.addr] <= fb_write.data;
        end
    end

    // read before write on an address collision
    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* src/matrix_scan.sv */
// row and plane scan sequencer
// shift slots, latch, binary-weighted display time, blank
`timescale 1ns/1ns
`include "led_matrix_macros.svh"

module matrix_scan (
    input  logic                   clk_root,
    input  logic                   arst_n,
    output logic                   fetch_start,
    output led_matrix_pkg::col_t   fetch_col,
    output led_matrix_pkg::row_t   scan_row,
    output led_matrix_pkg::plane_t plane,
    output led_matrix_pkg::row_t   row_addr,
    output logic                   clk_pixel,
    output logic                   row_latch,
    output logic                   oe_n
);

    localparam int SW = $clog2(`LM_SLOT_CYCLES);
    localparam int DW = $clog2(`LM_OE_UNIT << (`LM_PLANES - 1)) + 1;
    localparam logic [SW-1:0] SLOT_LAST = SW'(`LM_SLOT_CYCLES - 1);
    localparam led_matrix_pkg::col_t   COL_LAST   = `LM_COL_BITS'(`LM_COLS - 1);
    localparam led_matrix_pkg::plane_t PLANE_LAST = $bits(led_matrix_pkg::plane_t)'(`LM_PLANES - 1);

    // prime fetches the first column once after reset
    typedef enum logic [2:0] {PH_PRIME, PH_SHIFT, PH_LATCH, PH_DISPLAY, PH_BLANK} phase_t;

    phase_t               phase;
    logic [SW-1:0]        slot_cyc;
    led_matrix_pkg::col_t col;
    logic [DW-1:0]        disp_cnt;
    logic [DW-1:0]        disp_len;
    led_matrix_pkg::row_t row_q;
    led_matrix_pkg::row_t next_row;
    led_matrix_pkg::plane_t next_plane;

    assign disp_len   = DW'(`LM_OE_UNIT) << plane;
    assign next_plane = (plane == PLANE_LAST) ? '0 : plane + 1'b1;
    assign next_row   = (plane == PLANE_LAST) ? row_q + 1'b1 : row_q;

    // column c+1 is fetched while column c is shifted, column 0 during display
    assign fetch_start = (phase == PH_SHIFT && slot_cyc == '0 && col != COL_LAST) ||
                         ((phase == PH_DISPLAY || phase == PH_PRIME) && disp_cnt == '0);
    assign fetch_col   = (phase == PH_SHIFT) ? col + 1'b1 : '0;
    assign scan_row    = (phase == PH_DISPLAY || phase == PH_BLANK) ? next_row : row_q;

    assign clk_pixel = (phase == PH_SHIFT) && (slot_cyc >= SW'(`LM_SLOT_CYCLES / 2));
    assign row_latch = (phase == PH_LATCH);
    assign oe_n      = (phase != PH_DISPLAY);

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            phase    <= PH_PRIME;
            slot_cyc <= '0;
            col      <= '0;
            disp_cnt <= '0;
            plane    <= '0;
            row_q    <= '0;
            row_addr <= '0;
        end else begin
            case (phase)
                PH_PRIME: begin
                    disp_cnt <= disp_cnt + 1'b1;
                    if (disp_cnt == DW'(`LM_SLOT_CYCLES - 1)) phase <= PH_SHIFT;
                end
                PH_SHIFT: begin
                    slot_cyc <= slot_cyc + 1'b1;
                    if (slot_cyc == SLOT_LAST) begin
                        slot_cyc <= '0;
                        col      <= col + 1'b1;
                        if (col == COL_LAST) phase <= PH_LATCH;
                    end
                end
                PH_LATCH: begin
                    if (plane == '0) row_addr <= row_q;   // new row with its first plane
                    disp_cnt <= '0;
                    phase    <= PH_DISPLAY;
                end
                PH_DISPLAY: begin
                    disp_cnt <= disp_cnt + 1'b1;
                    if (disp_cnt == disp_len - 1'b1) phase <= PH_BLANK;
                end
                PH_BLANK: begin
                    plane <= next_plane;
                    row_q <= next_row;   // wraps after the last row pair
                    phase <= PH_SHIFT;
                end
                default: phase <= PH_PRIME;
            endcase
        end
    end

    a_latch_dark: assert property (@(posedge clk_root) disable iff (!arst_n)
        !(row_latch && !oe_n));
    a_latch_single: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |=> !row_latch);

endmodule

/* src/pixel_fetch.sv */
// top and bottom pixel read for one column
// pair register loads both halves together
`timescale 1ns/1ns

module pixel_fetch (
    input  logic                        clk_root,
    input  logic                        arst_n,
    input  logic                        fetch_start,
    input  led_matrix_pkg::col_t        fetch_col,
    input  led_matrix_pkg::row_t        scan_row,
    output led_matrix_pkg::fb_addr_t    rd_addr,
    input  led_matrix_pkg::pixel_t      rd_data,
    output led_matrix_pkg::pixel_pair_t pixels
);

    logic                   step1;   // bottom address out, top data back
    logic                   step2;   // bottom data back
    led_matrix_pkg::row_t   row_q;
    led_matrix_pkg::col_t   col_q;
    led_matrix_pkg::pixel_t top_q;

    // top half in the request cycle, bottom half one later
    assign rd_addr = step1 ? {1'b1, row_q, col_q} : {1'b0, scan_row, fetch_col};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            step1  <= 1'b0;
            step2  <= 1'b0;
            pixels <= '0;
        end else begin
            step1 <= fetch_start;
            step2 <= step1;
            if (step2) begin
                pixels.top    <= top_q;
                pixels.bottom <= rd_data;
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (fetch_start) begin
            row_q <= scan_row;
            col_q <= fetch_col;
        end
        if (step1) top_q <= rd_data;   // hold top until bottom arrives
    end

endmodule

/* src/pixel_shade.sv */
// current plane bit of one pixel, gated by colour and plane masks
`timescale 1ns/1ns

module pixel_shade (
    input  led_matrix_pkg::pixel_t        pixel,
    input  led_matrix_pkg::plane_t        plane,
    input  led_matrix_pkg::display_ctrl_t display_ctrl,
    output logic [2:0]                    rgb
);

    logic plane_on;

    always_comb begin
        plane_on = display_ctrl.plane_enable[plane];
        rgb[0]   = pixel.red[plane]   & display_ctrl.rgb_enable[0] & plane_on;
        rgb[1]   = pixel.green[plane] & display_ctrl.rgb_enable[1] & plane_on;
        rgb[2]   = pixel.blue[plane]  & display_ctrl.rgb_enable[2] & plane_on;
    end

endmodule

/* src/led_matrix_top.sv */
// led matrix driver top level
// uart in, frame memory, scan, fetch and one shader per panel half
`timescale 1ns/1ns

module led_matrix_top (
    input  logic                   clk_root,
    input  logic                   arst_n,
    input  logic                   rxd,
    output led_matrix_pkg::hub75_t panel
);

    logic [7:0]                    rx_byte;
    logic                          rx_valid;
    led_matrix_pkg::fb_write_t     fb_write;
    led_matrix_pkg::display_ctrl_t display_ctrl;
    led_matrix_pkg::fb_addr_t      rd_addr;
    led_matrix_pkg::pixel_t        rd_data;
    led_matrix_pkg::pixel_pair_t   pixels;
    logic                          fetch_start;
    led_matrix_pkg::col_t          fetch_col;
    led_matrix_pkg::row_t          scan_row;
    led_matrix_pkg::plane_t        plane;
    led_matrix_pkg::row_t          row_addr;
    logic                          clk_pixel;
    logic                          row_latch;
    logic                          oe_n;
    logic [2:0]                    rgb_top;
    logic [2:0]                    rgb_bottom;

    uart_byte_rx u_rx (.clk_root, .arst_n, .rxd, .rx_byte, .rx_valid);

    command_decoder u_decoder (
        .clk_root, .arst_n, .rx_byte, .rx_valid, .fb_write, .display_ctrl
    );

    frame_memory u_frame (.clk_root, .fb_write, .rd_addr, .rd_data);

    matrix_scan u_scan (
        .clk_root, .arst_n, .fetch_start, .fetch_col, .scan_row, .plane,
        .row_addr, .clk_pixel, .row_latch, .oe_n
    );

    pixel_fetch u_fetch (
        .clk_root, .arst_n, .fetch_start, .fetch_col, .scan_row,
        .rd_addr, .rd_data, .pixels
    );

    pixel_shade shade_top    (.pixel(pixels.top), .plane, .display_ctrl, .rgb(rgb_top));
    pixel_shade shade_bottom (.pixel(pixels.bottom), .plane, .display_ctrl, .rgb(rgb_bottom));

    assign panel = '{rgb_top:    rgb_top,
                     rgb_bottom: rgb_bottom,
                     row_addr:   row_addr,
                     clk_pixel:  clk_pixel,
                     row_latch:  row_latch,
                     oe_n:       oe_n};

endmodule

/* dv/led_matrix_tb.sv */
// led matrix testbench
// uart stimulus, shadow frame and masks, scan and pixel checks, watchdog
`timescale 1ns/1ns
`include "led_matrix_macros.svh"

module led_matrix_tb;

    localparam int N_TESTS      = 5;
    localparam int N_PIX        = 4;                          // pixel writes per test
    localparam int BYTE_CYCLES  = 12 * `LM_TICKS_PER_BIT;     // 10 bits plus 2 idle bits
    localparam int FRAME_CYCLES = `LM_SCAN_ROWS * (`LM_PLANES * (`LM_COLS * `LM_SLOT_CYCLES + 2)
                                  + `LM_OE_UNIT * ((1 << `LM_PLANES) - 1));
    localparam int UART_CYCLES  = N_PIX * 5 * BYTE_CYCLES;
    localparam int WATCHDOG_NS  = N_TESTS * 3 * (FRAME_CYCLES + UART_CYCLES) * 4;

    logic                   clk_root;
    logic                   arst_n;
    logic                   rxd;
    led_matrix_pkg::hub75_t panel;

    led_matrix_pkg::pixel_t shadow [256];
    logic [2:0]             shadow_rgb_en = 3'b111;
    logic [`LM_PLANES-1:0]  shadow_pl_en  = '1;

    integer seed;
    string  test_name    = "reset";
    int     errors       = 0;
    int     start_errors = 0;
    int     failed_tests = 0;
    int     tests_run    = 0;
    logic   busy         = 1'b0;   // command in flight, pixel checks off
    logic   cmd_done     = 1'b0;
    logic   started      = 1'b0;   // first shift phase seen
    int     frames       = 0;
    int     tb_row       = 0;
    int     tb_plane     = 0;
    int     col_idx      = 0;
    int     oe_low       = 0;
    int     oe_expect    = 0;
    logic   after_latch    = 1'b0;
    logic   prev_clk_pixel = 1'b0;
    logic   prev_oe_n      = 1'b1;
    logic [2:0] cap_top [`LM_COLS];
    logic [2:0] cap_bot [`LM_COLS];

    led_matrix_top uut (.clk_root, .arst_n, .rxd, .panel);

    initial begin
        clk_root = 1'b0;
        forever #2 clk_root = ~clk_root;
    end

    function automatic void note_error(string msg);
        $display("error in %s: %s", test_name, msg);
        errors++;
    endfunction

    function automatic void check_value(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("FAIL %s %s expected %0d actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endfunction

    // a colour bit needs its plane bit, its channel enable and its plane enable
    function automatic logic [2:0] shade(led_matrix_pkg::pixel_t pix, int p);
        logic [2:0] chan;
        chan = {pix.blue[p], pix.green[p], pix.red[p]};
        return chan & shadow_rgb_en & {3{shadow_pl_en[p]}};
    endfunction

    function automatic void check_latch();
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        check_value("clk_pixel pulses", `LM_COLS, col_idx);
        if (!busy) begin
            for (int c = 0; c < `LM_COLS; c++) begin
                exp_top = shade(shadow[tb_row * `LM_COLS + c], tb_plane);
                exp_bot = shade(shadow[(tb_row + `LM_SCAN_ROWS) * `LM_COLS + c], tb_plane);
                assert (cap_top[c] == exp_top && cap_bot[c] == exp_bot) else begin
                    $display("FAIL %s row %0d col %0d plane %0d expected %b/%b actual %b/%b",
                             test_name, tb_row, c, tb_plane, exp_top, exp_bot,
                             cap_top[c], cap_bot[c]);
                    errors++;
                end
            end
        end
    endfunction

    // outputs sampled mid-cycle
    always @(negedge clk_root) begin
        if (arst_n) begin
            if (after_latch) begin
                check_value("row_addr", tb_row, panel.row_addr);
                if (tb_row == `LM_SCAN_ROWS - 1 && tb_plane == `LM_PLANES - 1) begin
                    frames++;
                    if (busy && cmd_done) busy = 1'b0;   // next frame is fully fresh
                end
                tb_plane = (tb_plane + 1) % `LM_PLANES;
                if (tb_plane == 0) tb_row = (tb_row + 1) % `LM_SCAN_ROWS;
                after_latch = 1'b0;
            end
            if (panel.clk_pixel && !prev_clk_pixel) begin
                started = 1'b1;
                if (col_idx < `LM_COLS) begin
                    cap_top[col_idx] = panel.rgb_top;
                    cap_bot[col_idx] = panel.rgb_bottom;
                end
                col_idx++;
            end
            if (panel.row_latch) begin
                check_latch();
                oe_expect   = `LM_OE_UNIT << tb_plane;
                col_idx     = 0;
                after_latch = 1'b1;
            end
            if (!panel.oe_n) oe_low++;
            if (panel.oe_n && !prev_oe_n) begin
                check_value("oe_n low cycles", oe_expect, oe_low);
                oe_low = 0;
            end
            prev_clk_pixel = panel.clk_pixel;
            prev_oe_n      = panel.oe_n;
        end
    end

    a_dark_before_shift: assert property (@(negedge clk_root) disable iff (!arst_n)
        !started |-> (panel.oe_n && !panel.row_latch))
        else note_error("panel lit or latched before the first shift phase");

    a_latch_dark: assert property (@(negedge clk_root) disable iff (!arst_n)
        panel.row_latch |-> panel.oe_n)
        else note_error("row_latch high while oe_n is low");

    // start bit, 8 data bits lsb first, stop bit, two idle bits
    task automatic send_byte(input logic [7:0] b);
        logic [11:0] bits;
        bits = {3'b111, b, 1'b0};
        for (int i = 0; i < 12; i++) begin
            @(posedge clk_root);
            rxd <= bits[i];
            repeat (`LM_TICKS_PER_BIT - 1) @(posedge clk_root);
        end
    endtask

    task automatic write_random_pixel(input logic bottom);
        logic [3:0]             row;
        logic [3:0]             col;
        led_matrix_pkg::pixel_t pix;
        row      = {bottom, 3'($random(seed))};
        col      = 4'($random(seed));
        pix      = 12'($random(seed));
        busy     = 1'b1;
        cmd_done = 1'b0;
        send_byte(`LM_OP_PIXEL);
        send_byte({4'h0, row});
        send_byte({4'h0, col});
        send_byte({pix.red, pix.green});
        send_byte({4'h0, pix.blue});
        shadow[{row, col}] = pix;
        cmd_done = 1'b1;
    endtask

    task automatic set_mask(input logic [7:0] op, input logic [7:0] value);
        busy     = 1'b1;
        cmd_done = 1'b0;
        send_byte(op);
        send_byte(value);
        if (op == `LM_OP_ENABLE) shadow_rgb_en = value[2:0];
        else shadow_pl_en = value[`LM_PLANES-1:0];
        cmd_done = 1'b1;
    endtask

    // wait for the command to clear, then one whole checked frame
    task automatic settle();
        int target;
        wait (!busy);
        target = frames + 1;
        wait (frames >= target);
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        start_errors = errors;
    endtask

    task automatic end_test();
        int n;
        n = errors - start_errors;
        tests_run++;
        if (n != 0) failed_tests++;
        $display("test %-14s %s (%0d errors)", test_name, (n == 0) ? "ok" : "failed", n);
    endtask

    initial begin
        int         ch;
        logic [3:0] pm;
        seed   = 32'hbc74;
        arst_n = 1'b0;
        rxd    = 1'b1;
        for (int i = 0; i < 256; i++) shadow[i] = '0;
        repeat (5) @(posedge clk_root);
        arst_n <= 1'b1;

        start_test("reset");
        settle();
        end_test();

        start_test("pixel_top");
        for (int k = 0; k < N_PIX; k++) write_random_pixel(1'b0);
        settle();
        end_test();

        start_test("pixel_bottom");
        for (int k = 0; k < N_PIX; k++) write_random_pixel(1'b1);
        settle();
        end_test();

        start_test("colour_enable");
        ch = $unsigned($random(seed)) % 3;
        set_mask(`LM_OP_ENABLE, {5'h0, 3'b111 & ~(3'b001 << ch)});
        settle();
        end_test();

        start_test("plane_enable");
        set_mask(`LM_OP_ENABLE, 8'h07);
        pm = 4'($random(seed));
        if (pm == 4'hf) pm = 4'b0110;   // at least one plane off
        set_mask(`LM_OP_PLANES, {4'h0, pm});
        settle();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired in test %s after %0d ns", test_name, WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* all.f */
+incdir+src
src/led_matrix_pkg.sv
src/uart_byte_rx.sv
src/command_decoder.sv
src/frame_memory.sv
src/matrix_scan.sv
src/pixel_fetch.sv
src/pixel_shade.sv
src/led_matrix_top.sv
dv/led_matrix_tb.sv

/* run.sh */
#!/bin/sh
# build and run the led matrix testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module led_matrix_tb -o led_matrix_sim
./obj_dir/led_matrix_sim > sim.log 2>&1
cat sim.log

grep -q "Simulation finished: PASS" sim.log
